/* all.f */
common/histPkg.sv
histogram/histRam.sv
histogram/histAccumulator.sv
histogram/peakFinder.sv
verilog/histConfig.sv
verilog/histTop.sv
verification/histHandshake_chk.sv
verification/histTb.sv

/* common/histPkg.sv */
package histPkg;

    // default sizes, overridden from the top level
    localparam int PIXEL_WIDTH_DEF = 8;   // also the bin address width
    localparam int COUNT_WIDTH_DEF = 16;
    localparam int FRAME_WIDTH = 16;      // frame length register

    // register map of the host interface
    localparam logic [1:0] REG_FRAME_LEN = 2'd0;
    localparam logic [1:0] REG_COMMAND = 2'd1;

    // histogram control FSM
    typedef enum logic [2:0] {
        IDLE,       // waiting for start
        CLEAR,      // zeroing every bin
        WAIT_REQ,   // waiting for a pixel
        READ,       // old count on rdData
        WRITE,      // incremented count to RAM
        WAIT_DROP,  // ack high until req falls
        SCAN        // read port lent to the peak finder
    } accState;

endpackage

/* histogram/histAccumulator.sv */
`timescale 1ns/1ns

module histAccumulator import histPkg::*; #(
    parameter int pixelWidth = PIXEL_WIDTH_DEF,
    parameter int countWidth = COUNT_WIDTH_DEF
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  logic [FRAME_WIDTH-1:0] frameLength,
    input  logic                   pixReq,
    input  logic [pixelWidth-1:0]  pixData,
    output logic                   pixAck,
    output logic                   frameDone,
    input  logic                   scanActive,
    input  logic [pixelWidth-1:0]  scanAddr,
    output logic                   wrEn,
    output logic [pixelWidth-1:0]  wrAddr,
    output logic [countWidth-1:0]  wrData,
    output logic [pixelWidth-1:0]  rdAddr,
    input  logic [countWidth-1:0]  rdData
);

    accState state;
    logic [pixelWidth-1:0] clrAddr;
    logic [pixelWidth-1:0] pixLatch;
    logic [countWidth-1:0] newCount;
    logic [FRAME_WIDTH-1:0] pixCount;  // pixels accepted this frame
    logic scanSeen;                    // peak finder has started

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            clrAddr <= '0;
            pixCount <= '0;
            pixAck <= 1'b0;
            frameDone <= 1'b0;
            scanSeen <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CLEAR;
                        clrAddr <= '0;
                        pixCount <= '0;
                    end
                end
                CLEAR: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (&clrAddr) begin // last bin written this cycle
                        if (frameLength == '0) begin
                            frameDone <= 1'b1;
                            state <= SCAN;
                        end else begin
                            state <= WAIT_REQ;
                        end
                    end
                end
                WAIT_REQ: if (pixReq) state <= READ;
                READ: state <= WRITE;
                WRITE: begin
                    pixAck <= 1'b1; // count lands in RAM on this edge
                    pixCount <= pixCount + 1'b1;
                    state <= WAIT_DROP;
                end
                WAIT_DROP: begin
                    if (!pixReq) begin
                        pixAck <= 1'b0;
                        if (pixCount == frameLength) begin
                            frameDone <= 1'b1;
                            state <= SCAN;
                        end else begin
                            state <= WAIT_REQ;
                        end
                    end
                end
                SCAN: begin
                    // stay until the scan has run and finished
                    if (scanSeen && !scanActive) begin
                        scanSeen <= 1'b0;
                        state <= IDLE;
                    end else if (scanActive) begin
                        scanSeen <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_REQ && pixReq) begin
            pixLatch <= pixData;
        end
        if (state == READ) begin
            newCount <= (&rdData) ? rdData : rdData + 1'b1; // saturate at all ones
        end
    end

    always_comb begin
        wrEn = 1'b0;
        wrAddr = pixLatch;
        wrData = newCount;
        if (state == CLEAR) begin
            wrEn = 1'b1;
            wrAddr = clrAddr;
            wrData = '0;
        end else if (state == WRITE) begin
            wrEn = 1'b1;
        end
    end

    // pixData goes straight to the RAM so the read starts on the capture edge
    assign rdAddr = (state == SCAN) ? scanAddr : pixData;

endmodule

/* histogram/histRam.sv */
`timescale 1ns/1ns

module histRam import histPkg::*; #(
    parameter int pixelWidth = PIXEL_WIDTH_DEF,
    parameter int countWidth = COUNT_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  wrEn,
    input  logic [pixelWidth-1:0] wrAddr,
    input  logic [countWidth-1:0] wrData,
    input  logic [pixelWidth-1:0] rdAddr,
    output logic [countWidth-1:0] rdData
);

    logic [countWidth-1:0] mem [2**pixelWidth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr]; // one cycle read latency
    end

endmodule

/* histogram/peakFinder.sv */
`timescale 1ns/1ns

module peakFinder import histPkg::*; #(
    parameter int pixelWidth = PIXEL_WIDTH_DEF,
    parameter int countWidth = COUNT_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  scanStart,
    output logic                  scanActive,
    output logic [pixelWidth-1:0] scanAddr,
    input  logic [countWidth-1:0] rdData,
    output logic                  scanDone,
    output logic [pixelWidth-1:0] peakBin,
    output logic [countWidth-1:0] peakCount
);

    logic cmpValid;               // rdData belongs to cmpBin
    logic [pixelWidth-1:0] cmpBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanActive <= 1'b0;
            scanAddr <= '0;
            cmpValid <= 1'b0;
            scanDone <= 1'b0;
            peakBin <= '0;
            peakCount <= '0;
        end else begin
            cmpValid <= scanActive;
            scanDone <= cmpValid && !scanActive; // last bin compared now
            if (scanStart) begin
                scanActive <= 1'b1;
                scanAddr <= '0;
                peakBin <= '0;
                peakCount <= '0;
            end else begin
                if (scanActive) begin
                    if (&scanAddr) begin
                        scanActive <= 1'b0;
                    end else begin
                        scanAddr <= scanAddr + 1'b1;
                    end
                end
                // strictly greater, so a tie keeps the lower bin
                if (cmpValid && rdData > peakCount) begin
                    peakBin <= cmpBin;
                    peakCount <= rdData;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= scanAddr; // follows the RAM read latency
    end

endmodule

/* run.sh */
#!/bin/sh
# build the histogram testbench with Verilator and run it
# the exit status is the simulation's pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module histTb -o histSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/histSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi

exit 0

/* verification/histHandshake_chk.sv */
`timescale 1ns/1ns

module histHandshake_chk import histPkg::*; (
    input logic    clk,
    input logic    res,
    input logic    pixReq,
    input logic    pixAck,
    input logic    wrEn,
    input accState state
);

    // ack only answers a request that was already up
    ackNeedsReq: assert property (@(posedge clk) disable iff (!res)
        $rose(pixAck) |-> $past(pixReq))
        else $error("pixAck rose without a pending pixReq");

    ackHeld: assert property (@(posedge clk) disable iff (!res)
        pixAck && pixReq |=> pixAck) // held until the source lets go
        else $error("pixAck dropped while pixReq was still high");

    noWriteInIdle: assert property (@(posedge clk) disable iff (!res)
        state == IDLE |-> !wrEn)
        else $error("RAM write enable active in IDLE");

    resetQuiet: assert property (@(posedge clk)
        !res |-> !pixAck && !wrEn) // nothing moves under reset
        else $error("pixAck or wrEn active during reset");

endmodule

bind histAccumulator histHandshake_chk u_handshakeChk (
    .clk(clk),
    .res(res),
    .pixReq(pixReq),
    .pixAck(pixAck),
    .wrEn(wrEn),
    .state(state)
);

/* verification/histTb.sv */
`timescale 1ns/1ns

module histTb import histPkg::*; ();

    localparam int pixelWidth = 4;
    localparam int countWidth = 6;
    localparam int binCount = 2 ** pixelWidth;
    localparam int countMax = 2 ** countWidth - 1; // 63 is reachable in a short frame
    localparam int ackTimeout = 100;
    localparam int busyTimeout = 20;
    localparam int doneTimeout = 200;

    logic clk = 1'b0;
    logic res;
    logic cfgWrite;
    logic [1:0] cfgAddr;
    logic [FRAME_WIDTH-1:0] cfgData;
    logic pixReq;
    logic [pixelWidth-1:0] pixData;
    logic pixAck;
    logic busy;
    logic done;
    logic [pixelWidth-1:0] peakBin;
    logic [countWidth-1:0] peakCount;

    logic [31:0] seed;
    int model [binCount];            // reference histogram
    logic [pixelWidth-1:0] pixQ [$]; // pixels of the next frame

    histTop #(.pixelWidth(pixelWidth), .countWidth(countWidth)) u_histTop (
        .clk, .res, .cfgWrite, .cfgAddr, .cfgData, .pixReq, .pixData,
        .pixAck, .busy, .done, .peakBin, .peakCount
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            failRun($sformatf("CHECK FAILED %s expected %0d actual %0d",
                name, expected, actual));
        end
    endtask

    // all tasks start and end 1 ns after a rising edge
    task automatic writeReg(input logic [1:0] addr, input int value);
        cfgWrite = 1'b1;
        cfgAddr = addr;
        cfgData = FRAME_WIDTH'(value);
        @(posedge clk);
        #1;
        cfgWrite = 1'b0;
    endtask

    task automatic waitAck(input logic level);
        int cycles;
        cycles = 0;
        while (pixAck !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ackTimeout) begin
                failRun($sformatf("timed out waiting for pixAck to become %0d", level));
            end
        end
    endtask

    task automatic waitBusy();
        int cycles;
        cycles = 0;
        while (busy !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > busyTimeout) begin
                failRun("timed out waiting for busy after the start command");
            end
        end
    endtask

    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > doneTimeout) begin
                failRun("timed out waiting for done at the end of the frame");
            end
        end
    endtask

    task automatic fillRandom(input int n);
        pixQ.delete();
        repeat (n) begin
            seed = lcgNext(seed);
            pixQ.push_back(seed[27:24]); // upper bits are the better ones
        end
    endtask

    task automatic startFrame(input int len);
        foreach (model[i]) model[i] = 0;
        writeReg(REG_FRAME_LEN, len);
        writeReg(REG_COMMAND, 1);
        waitBusy();
    endtask

    task automatic sendPixel(input logic [pixelWidth-1:0] p);
        pixData = p;
        pixReq = 1'b1;
        waitAck(1'b1);
        pixReq = 1'b0;
        waitAck(1'b0); // ack must be low before the next req
        if (model[p] < countMax) begin
            model[p] = model[p] + 1;
        end
    endtask

    task automatic computePeak(output int bin, output int count);
        bin = 0;
        count = 0;
        for (int i = 0; i < binCount; i++) begin
            if (model[i] > count) begin // lowest bin wins a tie
                bin = i;
                count = model[i];
            end
        end
    endtask

    task automatic finishFrame(input string name);
        int expBin;
        int expCount;
        waitDone();
        computePeak(expBin, expCount);
        checkValue({name, " peakBin"}, expBin, int'(peakBin));
        checkValue({name, " peakCount"}, expCount, int'(peakCount));
        checkValue({name, " busy"}, 0, int'(busy));
    endtask

    task automatic runFrame(input string name);
        startFrame(pixQ.size());
        foreach (pixQ[i]) sendPixel(pixQ[i]);
        finishFrame(name);
    endtask

    initial begin
        res = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        pixReq = 1'b0;
        pixData = '0;
        seed = 32'h2b49;
        repeat (8) @(posedge clk);
        #1;
        res = 1'b1;
        checkValue("reset pixAck", 0, int'(pixAck));
        checkValue("reset busy", 0, int'(busy));
        checkValue("reset done", 0, int'(done));

        // writes while busy must not disturb the running frame
        fillRandom(5);
        startFrame(5);
        writeReg(REG_FRAME_LEN, 9);
        writeReg(REG_COMMAND, 1);
        checkValue("busy during frame", 1, int'(busy));
        checkValue("frame length while busy", 5, int'(u_histTop.frameLength));
        foreach (pixQ[i]) sendPixel(pixQ[i]);
        finishFrame("locked frame");

        fillRandom(40);
        runFrame("random frame");

        pixQ = '{4'd9, 4'd5, 4'd9, 4'd5, 4'd2, 4'd9, 4'd5};
        runFrame("tie frame");
        checkValue("tie lowest bin", 5, int'(peakBin));

        pixQ.delete();
        repeat (100) pixQ.push_back(4'd11);
        runFrame("saturation frame");
        checkValue("saturated count", countMax, int'(peakCount));

        fillRandom(20);
        runFrame("first of two frames");
        fillRandom(24);
        startFrame(24);
        checkValue("done cleared by start", 0, int'(done));
        foreach (pixQ[i]) sendPixel(pixQ[i]);
        finishFrame("second of two frames");

        pixQ.delete();
        runFrame("empty frame");
        checkValue("empty frame bin", 0, int'(peakBin));
        checkValue("empty frame count", 0, int'(peakCount));

        $display("TEST PASS");
        $finish;
    end

endmodule

/* verilog/histConfig.sv */
`timescale 1ns/1ns

module histConfig import histPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   cfgWrite,
    input  logic [1:0]             cfgAddr,
    input  logic [FRAME_WIDTH-1:0] cfgData,
    output logic [FRAME_WIDTH-1:0] frameLength,
    output logic                   start,
    input  logic                   frameDone,
    output logic                   scanStart,
    input  logic                   scanDone,
    output logic                   busy,
    output logic                   done
);

    logic locked;    // a frame is starting or running
    logic cmdWrite;
    logic lenWrite;

    assign locked = busy || start;
    assign cmdWrite = cfgWrite && cfgAddr == REG_COMMAND && cfgData == FRAME_WIDTH'(1);
    assign lenWrite = cfgWrite && cfgAddr == REG_FRAME_LEN;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frameLength <= '0;
            start <= 1'b0;
            scanStart <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            start <= cmdWrite && !locked;
            scanStart <= frameDone; // scan follows the frame by one cycle
            if (lenWrite && !locked) begin
                frameLength <= cfgData;
            end
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (scanDone) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

/* verilog/histTop.sv */
`timescale 1ns/1ns

module histTop import histPkg::*; #(
    parameter int pixelWidth = PIXEL_WIDTH_DEF,
    parameter int countWidth = COUNT_WIDTH_DEF
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   cfgWrite,
    input  logic [1:0]             cfgAddr,
    input  logic [FRAME_WIDTH-1:0] cfgData,
    input  logic                   pixReq,
    input  logic [pixelWidth-1:0]  pixData,
    output logic                   pixAck,
    output logic                   busy,
    output logic                   done,
    output logic [pixelWidth-1:0]  peakBin,
    output logic [countWidth-1:0]  peakCount
);

    logic [FRAME_WIDTH-1:0] frameLength;
    logic start, frameDone, scanStart, scanDone, scanActive, wrEn;
    logic [pixelWidth-1:0] scanAddr, wrAddr, rdAddr;
    logic [countWidth-1:0] wrData, rdData;

    histConfig u_histConfig (
        .clk, .res, .cfgWrite, .cfgAddr, .cfgData, .frameLength, .start,
        .frameDone, .scanStart, .scanDone, .busy, .done
    );

    histAccumulator #(.pixelWidth(pixelWidth), .countWidth(countWidth)) u_histAccumulator (
        .clk, .res, .start, .frameLength, .pixReq, .pixData, .pixAck, .frameDone,
        .scanActive, .scanAddr, .wrEn, .wrAddr, .wrData, .rdAddr, .rdData
    );

    peakFinder #(.pixelWidth(pixelWidth), .countWidth(countWidth)) u_peakFinder (
        .clk, .res, .scanStart, .scanActive, .scanAddr, .rdData, .scanDone,
        .peakBin, .peakCount
    );

    histRam #(.pixelWidth(pixelWidth), .countWidth(countWidth)) u_histRam (
        .clk, .wrEn, .wrAddr, .wrData, .rdAddr, .rdData
    );

endmodule
